//--- source/coreTypes.sv
package coreTypes;

    // Datapath widths
    localparam int xlen     = 32;                 // Data and PC width
    localparam int regAddrW = 5;                  // Register index width
    localparam int regCount = 32;                 // Architectural registers incl. x0
    localparam int shamtW   = 5;                  // Shift amount bits taken from operand B
    localparam int opcodeW  = 7;

    // Major opcodes handled by this slice
    localparam logic [opcodeW-1:0] opReg    = 7'b0110011;  // R-type ALU
    localparam logic [opcodeW-1:0] opImm    = 7'b0010011;  // I-type ALU
    localparam logic [opcodeW-1:0] opLui    = 7'b0110111;
    localparam logic [opcodeW-1:0] opBranch = 7'b1100011;  // Only BEQ and BNE

    // funct3 codes shared by R-type and I-type
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3Srl    = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // Branch funct3
    localparam logic [2:0] f3Beq = 3'b000;
    localparam logic [2:0] f3Bne = 3'b001;

    // funct7 values
    localparam logic [6:0] f7Base = 7'b0000000;
    localparam logic [6:0] f7Alt  = 7'b0100000;   // SUB

    // ALU operations, zero encodes add so a cleared bundle is harmless
    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluAnd   = 4'd2,
        aluOr    = 4'd3,
        aluXor   = 4'd4,
        aluSlt   = 4'd5,
        aluSll   = 4'd6,
        aluSrl   = 4'd7,
        aluPassB = 4'd8                           // LUI result is the immediate
    } aluOpT;

    // Decode-stage control
    typedef struct packed {
        logic  regWrite;                          // Writes rd at retire
        aluOpT aluOp;
        logic  aluSrcImm;                         // Operand B from imm
        logic  branchNe;                          // BNE polarity
        logic  branch;                            // BEQ or BNE
    } ctrlBundleT;

    // Contents of the decode/execute register
    typedef struct packed {
        logic                valid;
        ctrlBundleT          ctrl;
        logic [xlen-1:0]     pc;
        logic [xlen-1:0]     rs1Data;             // Register file value at decode
        logic [xlen-1:0]     rs2Data;
        logic [xlen-1:0]     imm;                 // Already sign extended
        logic [regAddrW-1:0] rs1;                 // Kept for forwarding compare
        logic [regAddrW-1:0] rs2;
        logic [regAddrW-1:0] rd;
    } decodeBundleT;

    // Contents of the execute/retire register and the top-level output
    typedef struct packed {
        logic                valid;
        logic                regWrite;
        logic [regAddrW-1:0] rd;
        logic [xlen-1:0]     result;
        logic                branchTaken;
        logic [xlen-1:0]     branchTarget;
        logic [xlen-1:0]     pc;
    } retireBundleT;

endpackage

//--- source/regFile.sv
`timescale 1ns/1ns

module regFile (
    input  logic                               clk,
    input  logic                               arstN,
    input  logic [coreTypes::regAddrW-1:0]     rs1Addr,
    input  logic [coreTypes::regAddrW-1:0]     rs2Addr,
    output logic [coreTypes::xlen-1:0]         rs1Data,
    output logic [coreTypes::xlen-1:0]         rs2Data,
    input  logic                               wrEn,
    input  logic [coreTypes::regAddrW-1:0]     wrAddr,
    input  logic [coreTypes::xlen-1:0]         wrData
);

    // x0 has no storage
    logic [coreTypes::xlen-1:0] regs [1:coreTypes::regCount-1];
    logic                       wrLive;             // Write that actually lands

    assign wrLive = wrEn && (wrAddr != '0);

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 1; i < coreTypes::regCount; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wrLive)
        begin
            regs[wrAddr] <= wrData;
        end
    end

    // Write-first read with x0 tied to zero
    function automatic logic [coreTypes::xlen-1:0] readPort(
        input logic [coreTypes::regAddrW-1:0] addr
    );
        logic [coreTypes::xlen-1:0] value;
        if (addr == '0)
            value = '0;
        else if (wrLive && (addr == wrAddr))
            value = wrData;                         // Bypass the pending write
        else
            value = regs[addr];
        return value;
    endfunction

    always_comb
    begin
        rs1Data = readPort(rs1Addr);
        rs2Data = readPort(rs2Addr);
    end

endmodule

//--- source/instrDecoder.sv
`timescale 1ns/1ns

module instrDecoder (
    input  logic                               instrValid,
    input  logic [coreTypes::xlen-1:0]         instr,
    input  logic [coreTypes::xlen-1:0]         pc,
    output logic [coreTypes::regAddrW-1:0]     rs1Addr,
    output logic [coreTypes::regAddrW-1:0]     rs2Addr,
    input  logic [coreTypes::xlen-1:0]         rs1Data,
    input  logic [coreTypes::xlen-1:0]         rs2Data,
    output coreTypes::decodeBundleT            decoded
);

    logic [coreTypes::opcodeW-1:0] opcode;
    logic [2:0]                    funct3;
    logic [6:0]                    funct7;
    coreTypes::ctrlBundleT         ctrl;           // Raw decode before valid gating
    logic [coreTypes::xlen-1:0]    imm;
    logic                          supported;      // Encoding is one we execute
    logic                          live;

    // Instruction fields
    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign rs1Addr = instr[19:15];
    assign rs2Addr = instr[24:20];

    always_comb
    begin
        ctrl      = '0;
        imm       = '0;
        supported = 1'b0;
        case (opcode)
            coreTypes::opReg:
            begin
                ctrl.regWrite = 1'b1;
                supported     = (funct7 == coreTypes::f7Base);  // Most R-type ops
                case (funct3)
                    coreTypes::f3AddSub:
                    begin
                        // SUB is the only alternate funct7 we accept
                        ctrl.aluOp = (funct7 == coreTypes::f7Alt) ? coreTypes::aluSub
                                                                  : coreTypes::aluAdd;
                        supported  = (funct7 == coreTypes::f7Base)
                                  || (funct7 == coreTypes::f7Alt);
                    end
                    coreTypes::f3And: ctrl.aluOp = coreTypes::aluAnd;
                    coreTypes::f3Or:  ctrl.aluOp = coreTypes::aluOr;
                    coreTypes::f3Xor: ctrl.aluOp = coreTypes::aluXor;
                    coreTypes::f3Slt: ctrl.aluOp = coreTypes::aluSlt;
                    coreTypes::f3Sll: ctrl.aluOp = coreTypes::aluSll;
                    coreTypes::f3Srl: ctrl.aluOp = coreTypes::aluSrl;
                    default:          supported  = 1'b0;           // SLTU
                endcase
            end
            coreTypes::opImm:
            begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                imm            = {{20{instr[31]}}, instr[31:20]};  // I-type
                supported      = 1'b1;
                case (funct3)
                    coreTypes::f3AddSub: ctrl.aluOp = coreTypes::aluAdd;
                    coreTypes::f3And:    ctrl.aluOp = coreTypes::aluAnd;
                    coreTypes::f3Or:     ctrl.aluOp = coreTypes::aluOr;
                    coreTypes::f3Xor:    ctrl.aluOp = coreTypes::aluXor;
                    coreTypes::f3Slt:    ctrl.aluOp = coreTypes::aluSlt;
                    default:             supported  = 1'b0;       // Immediate shifts, SLTIU
                endcase
            end
            coreTypes::opLui:
            begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = coreTypes::aluPassB;
                imm            = {instr[31:12], 12'b0};          // U-type
                supported      = 1'b1;
            end
            coreTypes::opBranch:
            begin
                // Equality checked on the subtract result
                ctrl.branch   = 1'b1;
                ctrl.aluOp    = coreTypes::aluSub;
                ctrl.branchNe = (funct3 == coreTypes::f3Bne);
                imm           = {{20{instr[31]}}, instr[7], instr[30:25],
                                 instr[11:8], 1'b0};             // B-type
                supported     = (funct3 == coreTypes::f3Beq)
                             || (funct3 == coreTypes::f3Bne);
            end
            default:
            begin
                supported = 1'b0;                                // Becomes a bubble
            end
        endcase
    end

    assign live = instrValid && supported;

    // Pack the bundle, a bubble carries no control
    always_comb
    begin
        decoded         = '0;
        decoded.valid   = live;
        decoded.ctrl    = live ? ctrl : '0;
        decoded.pc      = pc;
        decoded.rs1Data = rs1Data;
        decoded.rs2Data = rs2Data;
        decoded.imm     = imm;
        decoded.rs1     = rs1Addr;
        decoded.rs2     = rs2Addr;
        decoded.rd      = instr[11:7];
    end

endmodule

//--- source/pipeReg.sv
`timescale 1ns/1ns

module pipeReg #(
    parameter type payloadT = logic [7:0]
) (
    input  logic    clk,
    input  logic    arstN,
    input  logic    clear,    // Squash to a bubble at the next edge
    input  payloadT d,
    output payloadT q
);

    // All-zero payload is a bubble for every stage bundle
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            q <= payloadT'(0);
        end
        else if (clear)
        begin
            q <= payloadT'(0);    // Synchronous clear wins over capture
        end
        else
        begin
            q <= d;
        end
    end

endmodule

//--- source/execUnit.sv
`timescale 1ns/1ns

module execUnit (
    input  coreTypes::decodeBundleT stage,
    input  coreTypes::retireBundleT fwd,          // Retire register, one ahead
    output coreTypes::retireBundleT result,
    output logic                    branchTaken
);

    logic                       fwdLive;          // Retire stage will write a real register
    logic                       fwdRs1;
    logic                       fwdRs2;
    logic [coreTypes::xlen-1:0] srcA;
    logic [coreTypes::xlen-1:0] srcB;             // rs2 after forwarding
    logic [coreTypes::xlen-1:0] opB;              // After immediate select
    logic [coreTypes::shamtW-1:0] shamt;
    logic [coreTypes::xlen-1:0] aluOut;
    logic                       operandsEqual;

    // Forwarding from the retire register
    assign fwdLive = fwd.valid && fwd.regWrite && (fwd.rd != '0);
    assign fwdRs1  = fwdLive && (fwd.rd == stage.rs1);
    assign fwdRs2  = fwdLive && (fwd.rd == stage.rs2);

    assign srcA = fwdRs1 ? fwd.result : stage.rs1Data;
    assign srcB = fwdRs2 ? fwd.result : stage.rs2Data;
    assign opB  = stage.ctrl.aluSrcImm ? stage.imm : srcB;

    assign shamt = opB[coreTypes::shamtW-1:0];     // Only low bits shift

    always_comb
    begin
        case (stage.ctrl.aluOp)
            coreTypes::aluAdd:   aluOut = srcA + opB;
            coreTypes::aluSub:   aluOut = srcA - opB;
            coreTypes::aluAnd:   aluOut = srcA & opB;
            coreTypes::aluOr:    aluOut = srcA | opB;
            coreTypes::aluXor:   aluOut = srcA ^ opB;
            coreTypes::aluSlt:
            begin
                // Signed compare
                aluOut = {{(coreTypes::xlen-1){1'b0}}, ($signed(srcA) < $signed(opB))};
            end
            coreTypes::aluSll:   aluOut = srcA << shamt;
            coreTypes::aluSrl:   aluOut = srcA >> shamt;  // Logical
            coreTypes::aluPassB: aluOut = opB;
            default:             aluOut = '0;
        endcase
    end

    // BEQ/BNE use the subtract, zero means equal
    assign operandsEqual = (aluOut == '0);

    assign branchTaken = stage.valid && stage.ctrl.branch
                      && (operandsEqual ^ stage.ctrl.branchNe);

    // Retire bundle
    always_comb
    begin
        result              = '0;
        result.valid        = stage.valid;
        result.regWrite     = stage.valid && stage.ctrl.regWrite;  // Branches never write
        result.rd           = stage.rd;
        result.result       = aluOut;
        result.branchTaken  = branchTaken;
        result.branchTarget = stage.ctrl.branch ? (stage.pc + stage.imm) : '0;
        result.pc           = stage.pc;
    end

endmodule

//--- source/decodeExecCore.sv
`timescale 1ns/1ns

module decodeExecCore (
    input  logic                        clk,
    input  logic                        arstN,
    input  logic                        instrValid,  // instr and pc valid this cycle
    input  logic [coreTypes::xlen-1:0]  instr,
    input  logic [coreTypes::xlen-1:0]  pc,
    input  logic                        flush,       // Drop everything in flight
    output coreTypes::retireBundleT     retire
);

    logic [coreTypes::regAddrW-1:0] rs1Addr;
    logic [coreTypes::regAddrW-1:0] rs2Addr;
    logic [coreTypes::xlen-1:0]     rs1Data;
    logic [coreTypes::xlen-1:0]     rs2Data;
    coreTypes::decodeBundleT        decodeD;         // Decoder output
    coreTypes::decodeBundleT        decodeE;         // Held in execute
    coreTypes::retireBundleT        execOut;
    logic                           branchTaken;
    logic                           idExClear;

    // Decode stage
    instrDecoder decoder (
        .instrValid (instrValid),
        .instr      (instr),
        .pc         (pc),
        .rs1Addr    (rs1Addr),
        .rs2Addr    (rs2Addr),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data),
        .decoded    (decodeD)
    );

    // Written from the retire register
    regFile regs (
        .clk     (clk),
        .arstN   (arstN),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .wrEn    (retire.valid && retire.regWrite),
        .wrAddr  (retire.rd),
        .wrData  (retire.result)
    );

    // Taken branch squashes the younger instruction in decode
    assign idExClear = flush || branchTaken;

    pipeReg #(
        .payloadT (coreTypes::decodeBundleT)
    ) idEx (
        .clk   (clk),
        .arstN (arstN),
        .clear (idExClear),
        .d     (decodeD),
        .q     (decodeE)
    );

    // Execute stage
    execUnit exec (
        .stage       (decodeE),
        .fwd         (retire),
        .result      (execOut),
        .branchTaken (branchTaken)
    );

    pipeReg #(
        .payloadT (coreTypes::retireBundleT)
    ) exRet (
        .clk   (clk),
        .arstN (arstN),
        .clear (flush),
        .d     (execOut),
        .q     (retire)
    );

endmodule

//--- sim/refModel.svh
// Architectural state seen by the reference model
logic [coreTypes::xlen-1:0] modelRegs [0:coreTypes::regCount-1];
bit                         squashNext;            // Previous instruction was a taken branch

// Builds the expected retire bundle for one presented cycle and returns 0 when nothing retires
function automatic bit refRetire(
    input  bit                         valid,
    input  logic [coreTypes::xlen-1:0] instr,
    input  logic [coreTypes::xlen-1:0] pc,
    input  bit                         killed,     // Removed by a flush
    output coreTypes::retireBundleT    expBundle
);
    logic [6:0]                 op;
    logic [2:0]                 f3;
    logic [6:0]                 f7;
    logic [4:0]                 rd;
    logic [coreTypes::xlen-1:0] a;
    logic [coreTypes::xlen-1:0] b;
    logic [coreTypes::xlen-1:0] immI;
    logic [coreTypes::xlen-1:0] immB;
    logic [coreTypes::xlen-1:0] res;
    bit                         ok;
    bit                         squashed;
    expBundle  = '0;
    squashed   = squashNext;
    squashNext = 1'b0;
    if (!valid || killed || squashed)
        return 1'b0;
    op   = instr[6:0];
    f3   = instr[14:12];
    f7   = instr[31:25];
    rd   = instr[11:7];
    a    = modelRegs[instr[19:15]];
    b    = modelRegs[instr[24:20]];
    immI = {{20{instr[31]}}, instr[31:20]};
    immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    ok   = 1'b1;
    res  = '0;
    case (op)
        7'b0110011:                                // R-type
        begin
            ok = (f7 == 7'h00) || (f7 == 7'h20 && f3 == 3'b000);
            case (f3)
                3'b000: res = (f7 == 7'h20) ? a - b : a + b;
                3'b001: res = a << b[4:0];
                3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'b100: res = a ^ b;
                3'b101: res = a >> b[4:0];
                3'b110: res = a | b;
                3'b111: res = a & b;
                default: ok = 1'b0;                // SLTU not supported
            endcase
        end
        7'b0010011:                                // I-type
        begin
            case (f3)
                3'b000: res = a + immI;
                3'b010: res = ($signed(a) < $signed(immI)) ? 32'd1 : 32'd0;
                3'b100: res = a ^ immI;
                3'b110: res = a | immI;
                3'b111: res = a & immI;
                default: ok = 1'b0;
            endcase
        end
        7'b0110111: res = {instr[31:12], 12'b0};  // LUI
        7'b1100011:                                // BEQ and BNE only
        begin
            ok = (f3 == 3'b000) || (f3 == 3'b001);
            expBundle.branchTaken  = ok && ((a == b) ^ (f3 == 3'b001));
            expBundle.branchTarget = pc + immB;
        end
        default: ok = 1'b0;
    endcase
    if (!ok)
        return 1'b0;
    expBundle.valid    = 1'b1;
    expBundle.regWrite = (op != 7'b1100011);
    expBundle.rd       = rd;
    expBundle.result   = res;
    expBundle.pc       = pc;
    squashNext         = expBundle.branchTaken;
    if (expBundle.regWrite && rd != 5'd0)
        modelRegs[rd] = res;
    return 1'b1;
endfunction

//--- sim/decodeExecCoreTb.sv
`timescale 1ns/1ns

module decodeExecCoreTb;

    `include "refModel.svh"

    typedef struct {
        bit                         valid;
        logic [coreTypes::xlen-1:0] instr;
        logic [coreTypes::xlen-1:0] pc;
        bit                         flush;
    } stimT;

    typedef struct {
        int                      cyc;              // Cycle the instruction was presented
        bit                      has;
        coreTypes::retireBundleT bundle;
    } expT;

    logic                       clk;
    logic                       arstN;
    logic                       instrValid;
    logic [coreTypes::xlen-1:0] instr;
    logic [coreTypes::xlen-1:0] pc;
    logic                       flush;
    coreTypes::retireBundleT    retire;

    stimT                       stimQ [$];
    expT                        expQ [$];
    logic [coreTypes::xlen-1:0] nextPc;
    int                         driveCycle;        // Index of the cycle being presented
    int                         errorCount;
    int                         cycleLimit;
    bit                         limitReady;

    decodeExecCore decodeExecCore_inst (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .instr      (instr),
        .pc         (pc),
        .flush      (flush),
        .retire     (retire)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] encBranch(input logic [12:0] off, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input bit ne);
        return {off[12], off[10:5], rs2, rs1, {2'b00, ne}, off[4:1], off[11], 7'b1100011};
    endfunction

    task automatic pushStim(input bit v, input logic [31:0] word, input bit fl);
        stimT s;
        s.valid = v;
        s.instr = word;
        s.pc    = nextPc;
        s.flush = fl;
        stimQ.push_back(s);
        nextPc += 4;
    endtask

    // Random supported R-type or I-type op
    task automatic pushRandomAlu(input logic [4:0] rd, input logic [4:0] rs1,
                                 input logic [4:0] rs2);
        logic [2:0] rOps [7] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5, 3'd6, 3'd7};
        logic [2:0] iOps [5] = '{3'd0, 3'd2, 3'd4, 3'd6, 3'd7};
        logic [2:0] f3;
        if ($urandom % 2)
        begin
            f3 = rOps[$urandom % 7];
            pushStim(1, encR((f3 == 0 && ($urandom % 2)) ? 7'h20 : 7'h00, rs2, rs1, f3, rd), 0);
        end
        else
            pushStim(1, encI(12'($urandom), rs1, iOps[$urandom % 5], rd), 0);
    endtask

    task automatic checkValue(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (exp !== act)
        begin
            errorCount++;
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic buildStimulus();
        for (int r = 1; r < 32; r++)   // Load every register
        begin
            pushStim(1, {20'($urandom), 5'(r), 7'b0110111}, 0);
            pushStim(1, encI(12'($urandom), 5'(r), 3'b000, 5'(r)), 0);
        end
        for (int i = 0; i < 200; i++)
        begin
            pushRandomAlu(5'($urandom), 5'($urandom), 5'($urandom));
            if (i % 25 == 24)
                pushStim(0, $urandom, 0);      // Idle cycle with junk on instr
        end
        for (int i = 2; i < 22; i++)   // Dependency chains at distance one and two
            pushRandomAlu(5'(10 + i % 10), 5'(10 + (i - 1) % 10), 5'(10 + (i - 2) % 10));
        pushStim(1, {20'h12345, 5'd7, 7'b0110111}, 0);          // x7 nonzero
        pushStim(1, encBranch(13'h40, 5'd3, 5'd3, 0), 0);       // BEQ taken
        pushStim(1, encI(12'h011, 5'd1, 3'b000, 5'd2), 0);      // Squashed
        pushStim(1, encI(12'h022, 5'd2, 3'b000, 5'd2), 0);
        pushStim(1, encBranch(13'h1ff0, 5'd3, 5'd3, 1), 0);     // BNE not taken
        pushStim(1, encI(12'h033, 5'd2, 3'b000, 5'd4), 0);
        pushStim(1, encBranch(13'h0080, 5'd7, 5'd0, 1), 0);     // BNE taken
        pushStim(1, encBranch(13'h0010, 5'd3, 5'd3, 0), 0);     // Squashed branch
        pushStim(1, encBranch(13'h0100, 5'd7, 5'd0, 0), 0);     // BEQ not taken
        pushStim(1, encR(7'h00, 5'd4, 5'd2, 3'b000, 5'd5), 0);
        pushStim(1, encI(12'h005, 5'd1, 3'b000, 5'd0), 0);      // Write to x0
        pushStim(1, encR(7'h00, 5'd0, 5'd0, 3'b110, 5'd6), 0);  // Reads x0
        pushStim(1, encI(12'h001, 5'd0, 3'b000, 5'd8), 0);
        pushStim(1, 32'h0000_2083, 0);                          // Unsupported load
        pushStim(1, encR(7'h00, 5'd2, 5'd1, 3'b011, 5'd9), 0);  // Unsupported SLTU
        pushStim(1, encI(12'h101, 5'd8, 3'b000, 5'd9), 0);
        pushStim(1, encI(12'h7ff, 5'd9, 3'b000, 5'd9), 0);
        pushStim(1, encI(12'h001, 5'd9, 3'b000, 5'd9), 0);      // Removed by flush
        pushStim(1, encI(12'h002, 5'd9, 3'b000, 5'd9), 1);      // Presented with flush
        pushStim(0, 32'h0, 0);
        for (int i = 0; i < 10; i++)
            pushRandomAlu(5'(9 + i % 3), 5'(9 + (i + 2) % 3), 5'd9);
    endtask

    // Apply the reference to every cycle in order
    task automatic buildExpected();
        expT e;
        bit  killed;
        for (int j = 0; j < stimQ.size(); j++)
        begin
            killed = stimQ[j].flush || (j + 1 < stimQ.size() && stimQ[j + 1].flush);
            e.cyc  = j;
            e.has  = refRetire(stimQ[j].valid, stimQ[j].instr, stimQ[j].pc, killed, e.bundle);
            expQ.push_back(e);
        end
    endtask

    initial
    begin
        arstN      = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        pc         = '0;
        flush      = 1'b0;
        driveCycle = -10;
        errorCount = 0;
        limitReady = 0;
        nextPc     = 32'h0000_1000;
        squashNext = 0;
        for (int r = 0; r < 32; r++)
            modelRegs[r] = '0;
        void'($urandom(54));
        buildStimulus();
        buildExpected();
        cycleLimit = 2 * stimQ.size() + 50;
        limitReady = 1;
        repeat (5) @(posedge clk);
        arstN <= 1'b1;
        repeat (3) @(posedge clk);
        for (int j = 0; j < stimQ.size() + 4; j++)
        begin
            @(posedge clk);
            driveCycle = j;
            instrValid <= (j < stimQ.size()) ? stimQ[j].valid : 1'b0;
            instr      <= (j < stimQ.size()) ? stimQ[j].instr : '0;
            pc         <= (j < stimQ.size()) ? stimQ[j].pc : '0;
            flush      <= (j < stimQ.size()) ? stimQ[j].flush : 1'b0;
        end
        wait (expQ.size() == 0);
        @(negedge clk);
        $display("Run complete with %0d errors", errorCount);
        if (errorCount == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    // Compare at the falling edge where retire is stable
    always @(negedge clk)
    begin
        if (arstN && expQ.size() > 0 && expQ[0].cyc + 2 == driveCycle)
        begin
            if (expQ[0].has)
            begin
                checkValue("retire.valid", 1, retire.valid);
                checkValue("retire.regWrite", expQ[0].bundle.regWrite, retire.regWrite);
                checkValue("retire.branchTaken", expQ[0].bundle.branchTaken,
                           retire.branchTaken);
                checkValue("retire.pc", expQ[0].bundle.pc, retire.pc);
                if (expQ[0].bundle.regWrite)
                begin
                    checkValue("retire.rd", expQ[0].bundle.rd, retire.rd);
                    checkValue("retire.result", expQ[0].bundle.result, retire.result);
                end
                else
                    checkValue("retire.branchTarget", expQ[0].bundle.branchTarget,
                               retire.branchTarget);
            end
            else if (retire.valid)
            begin
                errorCount++;
                $display("ERROR at %0t: instruction of cycle %0d retired but should not",
                         $time, expQ[0].cyc);
            end
            void'(expQ.pop_front());
        end
        else if (arstN && (retire.valid || retire.regWrite || retire.branchTaken))
        begin
            errorCount++;
            $display("ERROR at %0t: retire active with no instruction expected", $time);
        end
    end

    initial
    begin
        int cycles;
        cycles = 0;
        wait (limitReady);
        while (cycles < cycleLimit)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("ERROR: timeout after %0d cycles, expected retires still pending", cycles);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- all.f
+incdir+sim
source/coreTypes.sv
source/regFile.sv
source/instrDecoder.sv
source/pipeReg.sv
source/execUnit.sv
source/decodeExecCore.sv
sim/decodeExecCoreTb.sv
